//--- sources.f
+incdir+test
verilog/evrPkg.sv
verilog/markerStretcher.sv
verilog/commaAlignDetect.sv
verilog/eventCodeOutput.sv
verilog/evrControlRegs.sv
verilog/evrReceiver.sv
test/evrReceiverTb.sv

//--- Bender.yml
package:
  name: evr_receiver

sources:
  # receiver RTL, package first
  - target: any(rtl, test)
    files:
      - verilog/evrPkg.sv
      - verilog/markerStretcher.sv
      - verilog/commaAlignDetect.sv
      - verilog/eventCodeOutput.sv
      - verilog/evrControlRegs.sv
      - verilog/evrReceiver.sv

  # testbench, top module evrReceiverTb
  - target: test
    include_dirs:
      - test
    files:
      - test/evrReceiverTb.sv

//--- test/evrModel.svh
// reference model state, its cycle update, xorshift generator and value compare

`ifndef EVR_MODEL_SVH
`define EVR_MODEL_SVH

int unsigned errorCount = 0;
int unsigned checkCount = 0;
logic [31:0] randState  = 32'hbfa5_9d09;               // fixed seed

////////////////////////////////////////////////////////////////////////////
// model state
int          mCommaRun     = 0;                        // consecutive good commas
rxByte_t     mCode         = '0;
logic        mValid        = 1'b0;
rxWordData_t mRaw          = '0;
charFlags_t  mIsK          = '0;
logic        mHbEvent      = 1'b0;                     // flag one cycle before marker
logic        mPpsEvent     = 1'b0;
int          mHbLeft       = 0;                        // marker cycles still to go
int          mPpsLeft      = 0;
logic        mSlideReq     = 1'b0;
logic        mSlideReqPrev = 1'b0;
logic        mSlide        = 1'b0;
rxByte_t     mLastCode     = '0;

function automatic logic modelAligned();
    return (mCommaRun >= COMMAS_NEEDED);
endfunction

// status layout: aligned, hb, pps in 2:0, last code in 15:8
function automatic statusWord_t modelStatus();
    statusWord_t s;
    s = '0;
    s[STATUS_ALIGNED_BIT] = modelAligned();
    s[STATUS_HB_BIT]      = (mHbLeft != 0);
    s[STATUS_PPS_BIT]     = (mPpsLeft != 0);
    s[STATUS_CODE_LSB +: 8] = mLastCode;
    return s;
endfunction

// one rising edge of evrClk, inputs as seen at that edge
task automatic modelStep(input logic rstN, input rxWord_t w, input logic wr,
                         input ctrlWord_t d);
    rxByte_t lowByte;
    logic    wasAligned;
    logic    good;
    lowByte    = w.data[7:0];
    wasAligned = modelAligned();
    good       = wasAligned && (lowByte != 8'h00) && !w.isK[0];
    if (!rstN) begin
        mCommaRun = 0;
        mCode = '0;
        mValid = 1'b0;
        mRaw = '0;
        mIsK = '0;
        mHbEvent = 1'b0;
        mPpsEvent = 1'b0;
        mHbLeft = 0;
        mPpsLeft = 0;
        mSlideReq = 1'b0;
        mSlideReqPrev = 1'b0;
        mSlide = 1'b0;
        mLastCode = '0;
    end else begin
        // stretchers and last code see last cycle's flags
        if (mHbEvent) mHbLeft = HB_STRETCH_CYCLES;
        else if (mHbLeft > 0) mHbLeft--;
        if (mPpsEvent) mPpsLeft = PPS_STRETCH_CYCLES;
        else if (mPpsLeft > 0) mPpsLeft--;
        if (mValid) mLastCode = mCode;
        mSlide        = mSlideReq && !mSlideReqPrev;   // 0 to 1 of stored bit
        mSlideReqPrev = mSlideReq;
        if (wr) mSlideReq = d[CTRL_SLIDE_BIT];
        mCode     = good ? lowByte : 8'h00;
        mValid    = good;
        mRaw      = w.data;
        mIsK      = w.isK;
        mHbEvent  = (lowByte == HB_EVENT_CODE) && !w.isK[0];
        mPpsEvent = good && (lowByte == PPS_EVENT_CODE);
        if ((w.notInTable != 2'b00) || w.isK[1]) mCommaRun = 0;
        else if (!wasAligned && w.isK[0] && (lowByte == COMMA_CHAR)) mCommaRun++;
    end
endtask

////////////////////////////////////////////////////////////////////////////
// helpers
function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = randState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    randState = x;
    return x;
endfunction

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
    end
endtask

`endif

//--- test/evrReceiverTb.sv
// event receiver testbench: clock, reset, directed and random word stimulus, checks

module evrReceiverTb import evrPkg::*; ();

    localparam int ALIGN_TIMEOUT = 500;                // cycles
    localparam int RANDOM_CYCLES = 3000;

    logic        evrClk;
    logic        rstN_i;
    rxWord_t     rxWord;
    logic        ctrlWrite;
    ctrlWord_t   ctrlData;
    rxByte_t     evrCode;
    logic        evrCodeValid;
    rxWordData_t rawRxWord;
    charFlags_t  charIsK;
    logic        aligned;
    logic        bitSlide;
    logic        hbMarker;
    logic        ppsMarker;
    statusWord_t status;

    int hbHighCount;                                   // marker/pulse cycle counters
    int ppsHighCount;
    int slideCount;

    `include "evrModel.svh"

    evrReceiver evrReceiver_inst (
        .evrClk        (evrClk),
        .rstN_i        (rstN_i),
        .rxWord_i      (rxWord),
        .ctrlWrite_i   (ctrlWrite),
        .ctrlData_i    (ctrlData),
        .evrCode_o     (evrCode),
        .evrCodeValid_o(evrCodeValid),
        .rawRxWord_o   (rawRxWord),
        .charIsK_o     (charIsK),
        .aligned_o     (aligned),
        .bitSlide_o    (bitSlide),
        .hbMarker_o    (hbMarker),
        .ppsMarker_o   (ppsMarker),
        .status_o      (status)
    );

    initial begin
        evrClk = 1'b0;
        forever #4 evrClk = ~evrClk;                   // period 8
    end

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle helpers
    task automatic checkOutputs();
        checkValue("evrCode_o", evrCode, mCode);
        checkValue("evrCodeValid_o", evrCodeValid, mValid);
        checkValue("rawRxWord_o", rawRxWord, mRaw);
        checkValue("charIsK_o", charIsK, mIsK);
        checkValue("aligned_o", aligned, modelAligned());
        checkValue("bitSlide_o", bitSlide, mSlide);
        checkValue("hbMarker_o", hbMarker, mHbLeft != 0);
        checkValue("ppsMarker_o", ppsMarker, mPpsLeft != 0);
        checkValue("status_o", status, modelStatus());
    endtask

    // model at the rising edge, checks at the falling edge
    task automatic stepCycle();
        @(posedge evrClk);
        modelStep(rstN_i, rxWord, ctrlWrite, ctrlData);
        @(negedge evrClk);
        checkOutputs();
        if (hbMarker) hbHighCount++;
        if (ppsMarker) ppsHighCount++;
        if (bitSlide) slideCount++;
    endtask

    task automatic driveWord(input rxWordData_t data, input charFlags_t isK,
                             input charFlags_t nit);
        rxWord.data       = data;
        rxWord.isK        = isK;
        rxWord.notInTable = nit;
        ctrlWrite         = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++) begin
            driveWord(16'h0000, 2'b00, 2'b00);
            stepCycle();
        end
    endtask

    task automatic sendCode(input rxByte_t code);
        driveWord({8'h5a, code}, 2'b00, 2'b00);        // upper byte is don't-care data
        stepCycle();
    endtask

    task automatic writeCtrl(input ctrlWord_t d);
        driveWord(16'h0000, 2'b00, 2'b00);
        ctrlWrite = 1'b1;
        ctrlData  = d;
        stepCycle();
    endtask

    // one random word, commas favoured while the model is not aligned
    task automatic driveRandom();
        logic [31:0] r;
        logic [31:0] r2;
        r  = xorshift32();
        r2 = xorshift32();
        if (r[31:24] < 8'd3) begin
            if (r[0]) driveWord(r2[15:0], 2'b00, (r[2:1] == 2'b00) ? 2'b01 : r[2:1]);
            else driveWord(r2[15:0], 2'b10, 2'b00);    // K in upper byte
        end else if (!modelAligned() && r[3:0] < 4'd12) begin
            driveWord({r2[15:8], COMMA_CHAR}, 2'b01, 2'b00);
        end else begin
            case (r[3:0])
                4'd0:    driveWord({r2[15:8], HB_EVENT_CODE}, 2'b00, 2'b00);
                4'd1:    driveWord({r2[15:8], PPS_EVENT_CODE}, 2'b00, 2'b00);
                4'd2:    driveWord({r2[15:8], 8'h00}, 2'b00, 2'b00);
                4'd3:    driveWord(r2[15:0], 2'b01, 2'b00);
                default: driveWord(r2[15:0], 2'b00, 2'b00);
            endcase
        end
        if (r[23:20] == 4'd0) begin
            ctrlWrite = 1'b1;
            ctrlData  = xorshift32();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        int commasSent;
        int waitCycles;
        rstN_i    = 1'b0;
        rxWord    = '0;
        ctrlWrite = 1'b0;
        ctrlData  = '0;
        stepCycle();
        stepCycle();
        rstN_i = 1'b1;

        // heartbeat without alignment, then a restart 21 edges later
        hbHighCount = 0;
        sendCode(HB_EVENT_CODE);
        idleCycles(59);
        checkValue("hb marker width", hbHighCount, HB_STRETCH_CYCLES);
        hbHighCount = 0;
        sendCode(HB_EVENT_CODE);
        idleCycles(20);
        sendCode(HB_EVENT_CODE);
        idleCycles(70);
        checkValue("hb restarted width", hbHighCount, 21 + HB_STRETCH_CYCLES);

        ppsHighCount = 0;                              // pps needs alignment
        sendCode(PPS_EVENT_CODE);
        idleCycles(20);
        checkValue("pps width unaligned", ppsHighCount, 0);

        // slide request, once from 0 and once repeated
        slideCount = 0;
        writeCtrl(32'h4000_0000);
        driveWord(16'h0000, 2'b00, 2'b00);
        stepCycle();
        checkValue("bitSlide_o two edges after write", bitSlide, 1);
        idleCycles(4);
        writeCtrl(32'h4000_0000);
        idleCycles(5);
        checkValue("slide pulse count", slideCount, 1);
        writeCtrl(32'h0000_0000);

        // partial comma run, restart by K in upper byte, then full run
        for (int i = 0; i < 25; i++) begin
            driveWord({8'h00, COMMA_CHAR}, 2'b01, 2'b00);
            stepCycle();
        end
        driveWord({COMMA_CHAR, COMMA_CHAR}, 2'b11, 2'b00);
        stepCycle();
        commasSent = 0;
        waitCycles = 0;
        while (!aligned && waitCycles < ALIGN_TIMEOUT) begin
            driveWord({8'h00, COMMA_CHAR}, 2'b01, 2'b00);
            stepCycle();
            commasSent++;
            waitCycles++;
        end

        if (!aligned) begin
            $display("timeout: aligned_o did not rise within %0d cycles", ALIGN_TIMEOUT);
            errorCount++;
        end else begin
            checkValue("commas to align", commasSent, COMMAS_NEEDED);
            ppsHighCount = 0;
            sendCode(PPS_EVENT_CODE);
            idleCycles(15);
            checkValue("pps marker width", ppsHighCount, PPS_STRETCH_CYCLES);
            driveWord(16'h1234, 2'b00, 2'b10);         // decode error
            stepCycle();
            checkValue("aligned_o after bad char", aligned, 0);
            for (int i = 0; i < RANDOM_CYCLES; i++) begin
                driveRandom();
                stepCycle();
            end
        end

        $display("evrReceiverTb finished: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/evrReceiver.sv
// event receiver top: control regs, comma alignment, code output, marker stretchers

module evrReceiver import evrPkg::*; (
    input  logic        evrClk,                        // recovered rx clock
    input  logic        rstN_i,                        // sync, active low

    // decoded word stream from transceiver
    input  rxWord_t     rxWord_i,

    // control write
    input  logic        ctrlWrite_i,                   // write strobe
    input  ctrlWord_t   ctrlData_i,

    // event code outputs
    output rxByte_t     evrCode_o,
    output logic        evrCodeValid_o,
    output rxWordData_t rawRxWord_o,                   // raw word, 1 cycle late
    output charFlags_t  charIsK_o,

    // receiver state and markers
    output logic        aligned_o,
    output logic        bitSlide_o,                    // to rx gearbox
    output logic        hbMarker_o,
    output logic        ppsMarker_o,
    output statusWord_t status_o
);

    // one-cycle event flags into the stretchers
    logic hbEvent;
    logic ppsEvent;

    ////////////////////////////////////////////////////////////////////////////
    // control and status
    evrControlRegs evrControlRegs_inst (
        .evrClk        (evrClk),
        .rstN_i        (rstN_i),
        .ctrlWrite_i   (ctrlWrite_i),
        .ctrlData_i    (ctrlData_i),
        .aligned_i     (aligned_o),
        .hbMarker_i    (hbMarker_o),
        .ppsMarker_i   (ppsMarker_o),
        .evrCode_i     (evrCode_o),
        .evrCodeValid_i(evrCodeValid_o),
        .bitSlide_o    (bitSlide_o),
        .status_o      (status_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // receiver alignment
    commaAlignDetect commaAlignDetect_inst (
        .evrClk   (evrClk),
        .rstN_i   (rstN_i),
        .rxWord_i (rxWord_i),
        .aligned_o(aligned_o)
    );

    // code qualification, raw word register, hb/pps flags
    eventCodeOutput eventCodeOutput_inst (
        .evrClk        (evrClk),
        .rstN_i        (rstN_i),
        .rxWord_i      (rxWord_i),
        .aligned_i     (aligned_o),
        .evrCode_o     (evrCode_o),
        .evrCodeValid_o(evrCodeValid_o),
        .rawRxWord_o   (rawRxWord_o),
        .charIsK_o     (charIsK_o),
        .hbEvent_o     (hbEvent),
        .ppsEvent_o    (ppsEvent)
    );

    ////////////////////////////////////////////////////////////////////////////
    // marker stretching
    markerStretcher #(
        .STRETCH_CYCLES(HB_STRETCH_CYCLES)
    ) hbStretch (
        .evrClk   (evrClk),
        .rstN_i   (rstN_i),
        .trigger_i(hbEvent),                           // no alignment needed
        .marker_o (hbMarker_o)
    );

    markerStretcher #(
        .STRETCH_CYCLES(PPS_STRETCH_CYCLES)
    ) ppsStretch (
        .evrClk   (evrClk),
        .rstN_i   (rstN_i),
        .trigger_i(ppsEvent),                          // good codes only
        .marker_o (ppsMarker_o)
    );

endmodule

//--- verilog/evrControlRegs.sv
// control write decode, slide pulse, last event code capture and status word

module evrControlRegs import evrPkg::*; (
    input  logic        evrClk,
    input  logic        rstN_i,                        // sync, active low
    input  logic        ctrlWrite_i,                   // control write strobe
    input  ctrlWord_t   ctrlData_i,
    input  logic        aligned_i,
    input  logic        hbMarker_i,
    input  logic        ppsMarker_i,
    input  rxByte_t     evrCode_i,
    input  logic        evrCodeValid_i,
    output logic        bitSlide_o,                    // one-cycle gearbox slide
    output statusWord_t status_o
);

    logic    slideReq;                                 // stored control bit
    logic    slideReqD;                                // previous value, edge detect
    rxByte_t lastCode;                                 // most recent good code

    ////////////////////////////////////////////////////////////////////////////
    // slide request
    always_ff @(posedge evrClk) begin
        if (!rstN_i) begin
            slideReq   <= 1'b0;
            slideReqD  <= 1'b0;
            bitSlide_o <= 1'b0;
        end else begin
            if (ctrlWrite_i) begin
                slideReq <= ctrlData_i[CTRL_SLIDE_BIT];
            end
            slideReqD  <= slideReq;
            // rising edge only, so a repeated write with bit set stays quiet
            bitSlide_o <= slideReq && !slideReqD;
        end
    end

    // last good code, held until the next one
    always_ff @(posedge evrClk) begin
        if (!rstN_i) begin
            lastCode <= '0;
        end else if (evrCodeValid_i) begin
            lastCode <= evrCode_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // status readback
    always_comb begin
        status_o                                      = '0;  // unused bits read 0
        status_o[STATUS_ALIGNED_BIT]                  = aligned_i;
        status_o[STATUS_HB_BIT]                       = hbMarker_i;
        status_o[STATUS_PPS_BIT]                      = ppsMarker_i;
        status_o[STATUS_CODE_LSB +: $bits(rxByte_t)]  = lastCode;
    end

    // the gearbox must see isolated slide pulses
    slidePulseSingle: assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        bitSlide_o |=> !bitSlide_o
    ) else $error("bitSlide_o high on two consecutive cycles");

endmodule

//--- verilog/eventCodeOutput.sv
// event code qualification, raw word register and heartbeat/pps event flags

module eventCodeOutput import evrPkg::*; (
    input  logic        evrClk,
    input  logic        rstN_i,                        // sync, active low
    input  rxWord_t     rxWord_i,
    input  logic        aligned_i,                     // from comma detector
    output rxByte_t     evrCode_o,                     // 0 when not a good code
    output logic        evrCodeValid_o,
    output rxWordData_t rawRxWord_o,
    output charFlags_t  charIsK_o,
    output logic        hbEvent_o,                     // one cycle per 122
    output logic        ppsEvent_o                     // one cycle per good 125
);

    rxByte_t lowByte;                                  // first byte in time
    logic    goodCode;

    assign lowByte  = rxWord_i.data[$bits(rxByte_t)-1:0];
    assign goodCode = aligned_i && (lowByte != '0) && !rxWord_i.isK[0];

    ////////////////////////////////////////////////////////////////////////////
    // 1-cycle output register
    always_ff @(posedge evrClk) begin
        if (!rstN_i) begin
            evrCode_o      <= '0;
            evrCodeValid_o <= 1'b0;
            rawRxWord_o    <= '0;
            charIsK_o      <= '0;
            hbEvent_o      <= 1'b0;
            ppsEvent_o     <= 1'b0;
        end else begin
            evrCode_o      <= goodCode ? lowByte : '0;
            evrCodeValid_o <= goodCode;
            rawRxWord_o    <= rxWord_i.data;           // observation only
            charIsK_o      <= rxWord_i.isK;
            // heartbeat ignores alignment, any non-K 122
            hbEvent_o      <= (lowByte == HB_EVENT_CODE) && !rxWord_i.isK[0];
            ppsEvent_o     <= goodCode && (lowByte == PPS_EVENT_CODE);
        end
    end

    // valid never flags the idle code
    validNonzero: assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        evrCodeValid_o |-> (evrCode_o != '0)
    ) else $error("evrCodeValid_o high with zero event code");

endmodule

//--- verilog/commaAlignDetect.sv
// comma counter that declares and withdraws receiver alignment

module commaAlignDetect import evrPkg::*; (
    input  logic    evrClk,
    input  logic    rstN_i,                            // sync, active low
    input  rxWord_t rxWord_i,                          // decoded word stream
    output logic    aligned_o
);

    // counts 59 down past zero, sign bit set after the 60th comma
    localparam logic signed [COMMA_CNT_WIDTH-1:0] COMMA_RELOAD =
        COMMA_CNT_WIDTH'(COMMAS_NEEDED - 1);

    logic signed [COMMA_CNT_WIDTH-1:0] commaCnt;
    logic                              rxError;        // decode error or bad K
    logic                              goodComma;

    // a K in the upper byte never belongs there
    assign rxError   = (rxWord_i.notInTable != '0) || rxWord_i.isK[1];

    assign goodComma = rxWord_i.isK[0]
                    && (rxWord_i.data[$bits(rxByte_t)-1:0] == COMMA_CHAR);

    assign aligned_o = commaCnt[COMMA_CNT_WIDTH-1];    // straight from sign bit

    ////////////////////////////////////////////////////////////////////////////
    // counter
    always_ff @(posedge evrClk) begin
        if (!rstN_i) begin
            commaCnt <= COMMA_RELOAD;
        end else if (rxError) begin
            commaCnt <= COMMA_RELOAD;                  // start over
        end else if (!aligned_o && goodComma) begin
            commaCnt <= commaCnt - 1'b1;
        end
        // once aligned, counter freezes until an error
    end

    // an error word withdraws alignment at its own edge
    errorDropsAlign: assert property (
        @(posedge evrClk) disable iff (!rstN_i)
        (rxWord_i.notInTable != '0) |=> !aligned_o
    ) else $error("aligned_o still high after a not-in-table character");

endmodule

//--- verilog/markerStretcher.sv
// retriggerable down-counter that widens a one-cycle event into a fixed marker

module markerStretcher #(
    parameter int STRETCH_CYCLES = 16                  // marker length in cycles
) (
    input  logic evrClk,
    input  logic rstN_i,                               // sync, active low
    input  logic trigger_i,                            // one-cycle event
    output logic marker_o
);

    localparam int CNT_WIDTH = $clog2(STRETCH_CYCLES + 1);

    // cycles of marker still to go
    logic [CNT_WIDTH-1:0] stretchCnt;

    ////////////////////////////////////////////////////////////////////////////
    // counter
    always_ff @(posedge evrClk) begin
        if (!rstN_i) begin
            stretchCnt <= '0;
        end else if (trigger_i) begin
            stretchCnt <= CNT_WIDTH'(STRETCH_CYCLES);  // (re)start full length
        end else if (stretchCnt != '0) begin
            stretchCnt <= stretchCnt - 1'b1;
        end
    end

    // high from the edge after trigger for STRETCH_CYCLES cycles
    assign marker_o = (stretchCnt != '0);

endmodule

//--- verilog/evrPkg.sv
// shared widths, word types, event codes, status layout and stretch lengths

package evrPkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    localparam int RX_BYTE_WIDTH   = 8;                 // one 8b10b decoded byte
    localparam int RX_WORD_BYTES   = 2;                 // transceiver delivers 2 bytes/clk
    localparam int RX_WORD_WIDTH   = RX_BYTE_WIDTH * RX_WORD_BYTES;
    localparam int CTRL_WIDTH      = 32;
    localparam int STATUS_WIDTH    = 32;

    // one received byte, also used for event codes
    typedef logic [RX_BYTE_WIDTH-1:0] rxByte_t;

    // two bytes, low byte first in time
    typedef logic [RX_WORD_WIDTH-1:0] rxWordData_t;

    // per-byte flag pair: K flags, not-in-table flags
    typedef logic [RX_WORD_BYTES-1:0] charFlags_t;

    typedef logic [CTRL_WIDTH-1:0]   ctrlWord_t;       // control write data
    typedef logic [STATUS_WIDTH-1:0] statusWord_t;     // status readback

    // decoded transceiver output, one per evrClk cycle
    typedef struct packed {
        rxWordData_t data;                             // received bytes
        charFlags_t  isK;                              // control character flags
        charFlags_t  notInTable;                       // decoder error flags
    } rxWord_t;

    ////////////////////////////////////////////////////////////////////////////
    // alignment
    localparam rxByte_t COMMA_CHAR      = 8'hBC;       // K28.5
    localparam int      COMMAS_NEEDED   = 60;          // good commas before aligned
    localparam int      COMMA_CNT_WIDTH = 7;           // 59 plus sign bit

    ////////////////////////////////////////////////////////////////////////////
    // event codes
    localparam rxByte_t HB_EVENT_CODE   = 8'd122;      // heartbeat
    localparam rxByte_t PPS_EVENT_CODE  = 8'd125;      // pulse per second

    // marker lengths, kept short for simulation
    localparam int HB_STRETCH_CYCLES    = 48;
    localparam int PPS_STRETCH_CYCLES   = 12;

    ////////////////////////////////////////////////////////////////////////////
    // control and status bit positions
    localparam int CTRL_SLIDE_BIT       = 30;          // rx gearbox slide request

    localparam int STATUS_ALIGNED_BIT   = 0;
    localparam int STATUS_HB_BIT        = 1;
    localparam int STATUS_PPS_BIT       = 2;
    localparam int STATUS_CODE_LSB      = 8;           // last good code in 15:8

endpackage
